/* rtl/sram_arb_pkg.sv */
`default_nettype none

package sram_arb_pkg;

    // requester counts, reads at 0..4 and writes at 5..9
    localparam int unsigned RD_REQ_NUM = 5;
    localparam int unsigned WR_REQ_NUM = 5;
    localparam int unsigned REQ_NUM    = RD_REQ_NUM + WR_REQ_NUM;
    localparam int unsigned RR_PTR_W   = $clog2(REQ_NUM);

    // booking registers
    localparam int unsigned RAM_NUM     = 8;
    localparam int unsigned CH_NUM      = 2;
    localparam int unsigned RAM_TIMER_W = 20;
    localparam int unsigned CH_TIMER_W  = 10;
    localparam int unsigned RAM_IDX_W   = $clog2(RAM_TIMER_W);
    localparam int unsigned CH_IDX_W    = $clog2(CH_TIMER_W);

    localparam int unsigned RD_BLOCK_DELAY0 = 1;
    localparam int unsigned RD_BLOCK_DELAY1 = 2;
    localparam int unsigned RD_BLOCK_DELAY2 = 3;
    localparam int unsigned RD_BLOCK_DELAY3 = 4;
    localparam int unsigned WR_BLOCK_DELAY0 = 8;
    localparam int unsigned WR_BLOCK_DELAY1 = 7;
    localparam int unsigned WR_BLOCK_DELAY2 = 6;
    localparam int unsigned WR_BLOCK_DELAY3 = 5;
    localparam int unsigned WR_CMD_DELAY_WEST  = 3;
    localparam int unsigned WR_CMD_DELAY_EAST  = 5;
    localparam int unsigned WR_CMD_DELAY_SOUTH = 7;
    localparam int unsigned WR_CMD_DELAY_NORTH = 9;
    localparam int unsigned WR_CMD_DELAY_LF    = 6;

    typedef enum logic [1:0] {
        DIR_WEST  = 2'd0,
        DIR_EAST  = 2'd1,
        DIR_SOUTH = 2'd2,
        DIR_NORTH = 2'd3
    } dir_e;

    typedef enum logic [1:0] {
        OP_READ     = 2'd0,
        OP_WRITE    = 2'd1,
        OP_LINEFILL = 2'd2
    } op_e;

    typedef struct packed {
        op_e        opcode;
        dir_e       direction;
        logic [2:0] dest_ram; // {block, sram select}
        logic [3:0] tag;
    } req_pld_t;

    // ram bit a read must find clear
    function automatic logic [RAM_IDX_W-1:0] rd_ram_bit(input logic [1:0] blk);
        logic [RAM_IDX_W-1:0] b;
        case (blk)
            2'd0:    b = RAM_IDX_W'(RD_BLOCK_DELAY0);
            2'd1:    b = RAM_IDX_W'(RD_BLOCK_DELAY1);
            2'd2:    b = RAM_IDX_W'(RD_BLOCK_DELAY2);
            default: b = RAM_IDX_W'(RD_BLOCK_DELAY3);
        endcase
        return b;
    endfunction

    // cycles until a write occupies its channel
    function automatic logic [CH_IDX_W-1:0] wr_cmd_delay(input logic is_lf, input dir_e dir);
        logic [CH_IDX_W-1:0] d;
        if (is_lf) begin
            d = CH_IDX_W'(WR_CMD_DELAY_LF); // linefill has no direction
        end else begin
            case (dir)
                DIR_WEST:  d = CH_IDX_W'(WR_CMD_DELAY_WEST);
                DIR_EAST:  d = CH_IDX_W'(WR_CMD_DELAY_EAST);
                DIR_SOUTH: d = CH_IDX_W'(WR_CMD_DELAY_SOUTH);
                default:   d = CH_IDX_W'(WR_CMD_DELAY_NORTH);
            endcase
        end
        return d;
    endfunction

    function automatic logic [RAM_IDX_W-1:0] wr_blk_delay(input logic [1:0] blk);
        logic [RAM_IDX_W-1:0] b;
        case (blk)
            2'd0:    b = RAM_IDX_W'(WR_BLOCK_DELAY0);
            2'd1:    b = RAM_IDX_W'(WR_BLOCK_DELAY1);
            2'd2:    b = RAM_IDX_W'(WR_BLOCK_DELAY2);
            default: b = RAM_IDX_W'(WR_BLOCK_DELAY3);
        endcase
        return b;
    endfunction

endpackage

`default_nettype wire

/* rtl/access_hazard_check.sv */
`default_nettype none

module access_hazard_check
    import sram_arb_pkg::*;
(
    input  logic [RD_REQ_NUM-1:0]                rd_vld,
    input  req_pld_t                             rd_pld [RD_REQ_NUM-1:0],
    input  logic [WR_REQ_NUM-1:0]                wr_vld,
    input  req_pld_t                             wr_pld [WR_REQ_NUM-1:0],
    input  logic [RAM_NUM-1:0][RAM_TIMER_W-1:0]  ram_busy,
    input  logic [CH_NUM-1:0][CH_TIMER_W-1:0]    ch_busy,
    output logic [REQ_NUM-1:0]                   elig_ch0,
    output logic [REQ_NUM-1:0]                   elig_ch1
);

    logic [REQ_NUM-1:0] ok;    // valid and clear of every booking
    logic [REQ_NUM-1:0] sel;   // sram select per requester

    always_comb begin
        logic [2:0]           ram;
        logic [CH_IDX_W-1:0]  d;
        logic [RAM_IDX_W-1:0] rb;
        ok  = '0;
        sel = '0;
        ram = '0;
        d   = '0;
        rb  = '0;
        for (int r = 0; r < RD_REQ_NUM; r++) begin
            ram    = rd_pld[r].dest_ram;
            rb     = rd_ram_bit(ram[2:1]);
            sel[r] = ram[0];
            ok[r]  = rd_vld[r] & ~ch_busy[ram[0]][0] & ~ram_busy[ram][rb]; // channel free next cycle
        end
        // write 0 is the linefill path whatever its direction
        for (int w = 0; w < WR_REQ_NUM; w++) begin
            ram = wr_pld[w].dest_ram;
            d   = wr_cmd_delay(w == 0, wr_pld[w].direction);
            rb  = RAM_IDX_W'(d) + wr_blk_delay(ram[2:1]);
            sel[RD_REQ_NUM+w] = ram[0];
            ok[RD_REQ_NUM+w]  = wr_vld[w] & ~ch_busy[ram[0]][d] & ~ram_busy[ram][rb];
        end
    end

    assign elig_ch0 = ok & ~sel;
    assign elig_ch1 = ok & sel;

    always_comb begin
        a_disjoint: assert ((elig_ch0 & elig_ch1) == '0)
            else $error("request eligible on both channels");
    end

endmodule

`default_nettype wire

/* rtl/busy_timers.sv */
`default_nettype none

module busy_timers
    import sram_arb_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 take0,
    input  req_pld_t                             pld0,
    input  logic                                 take1,
    input  req_pld_t                             pld1,
    output logic [RAM_NUM-1:0][RAM_TIMER_W-1:0]  ram_busy,
    output logic [CH_NUM-1:0][CH_TIMER_W-1:0]    ch_busy
);

    logic [1:0]             take;
    req_pld_t               pld      [2];
    logic [CH_TIMER_W-1:0]  ch_mask  [2];
    logic [RAM_TIMER_W-1:0] ram_mask [2];

    logic [RAM_NUM-1:0][RAM_TIMER_W-1:0] ram_set;
    logic [CH_NUM-1:0][CH_TIMER_W-1:0]   ch_set;

    assign take   = {take1, take0};
    assign pld[0] = pld0;
    assign pld[1] = pld1;

    // booking masks of the accepted grant on each port
    for (genvar p = 0; p < 2; p++) begin : g_port
        logic                 is_lf;
        logic                 books;
        logic [CH_IDX_W-1:0]  ch_bit;
        logic [RAM_IDX_W-1:0] ram_bit;

        assign is_lf   = (pld[p].opcode == OP_LINEFILL);
        assign books   = take[p] & ((pld[p].opcode == OP_WRITE) | is_lf); // reads book nothing
        assign ch_bit  = wr_cmd_delay(is_lf, pld[p].direction);
        assign ram_bit = RAM_IDX_W'(ch_bit) + wr_blk_delay(pld[p].dest_ram[2:1]);

        always_comb begin
            ch_mask[p]           = '0;
            ram_mask[p]          = '0;
            ch_mask[p][ch_bit]   = books;
            ram_mask[p][ram_bit] = books;
        end

        // steering upstream must keep each port on its own channel
        a_port_sel: assert property (@(posedge clk) disable iff (!rst_n)
            take[p] |-> (pld[p].dest_ram[0] == 1'(p)))
            else $error("grant on port %0d names the other sram select", p);
    end

    // route each mask to the ram and channel its payload names
    always_comb begin
        ram_set = '0;
        ch_set  = '0;
        for (int p = 0; p < 2; p++) begin
            ram_set[pld[p].dest_ram]  = ram_set[pld[p].dest_ram] | ram_mask[p];
            ch_set[pld[p].dest_ram[0]] = ch_set[pld[p].dest_ram[0]] | ch_mask[p];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_busy <= '0;
            ch_busy  <= '0;
        end else begin
            for (int r = 0; r < RAM_NUM; r++) begin
                ram_busy[r] <= (ram_busy[r] >> 1) | ram_set[r]; // bit 0 is the next cycle
            end
            for (int c = 0; c < CH_NUM; c++) begin
                ch_busy[c] <= (ch_busy[c] >> 1) | ch_set[c];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/rr_arb.sv */
`default_nettype none

module rr_arb
    import sram_arb_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [REQ_NUM-1:0] req,
    input  logic               take,
    output logic [REQ_NUM-1:0] gnt
);

    logic [RR_PTR_W-1:0] ptr;   // highest priority requester
    logic [RR_PTR_W-1:0] win;
    logic [RR_PTR_W:0]   cand;
    logic                found;

    // search from the pointer upward, wrapping at REQ_NUM
    always_comb begin
        found = 1'b0;
        win   = ptr;
        cand  = '0;
        gnt   = '0;
        for (int k = 0; k < REQ_NUM; k++) begin
            cand = {1'b0, ptr} + (RR_PTR_W+1)'(k);
            if (cand >= (RR_PTR_W+1)'(REQ_NUM)) begin
                cand = cand - (RR_PTR_W+1)'(REQ_NUM);
            end
            if (!found && req[cand[RR_PTR_W-1:0]]) begin
                found = 1'b1;
                win   = cand[RR_PTR_W-1:0];
            end
        end
        if (found) begin
            gnt[win] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (take) begin
            ptr <= (win == RR_PTR_W'(REQ_NUM - 1)) ? '0 : win + 1'b1; // one past the winner
        end
    end

    a_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt))
        else $error("grant vector not one-hot");

    a_subset: assert property (@(posedge clk) disable iff (!rst_n) (gnt & ~req) == '0)
        else $error("grant without a request");

endmodule

`default_nettype wire

/* rtl/sram_port_arb.sv */
`default_nettype none

module sram_port_arb
    import sram_arb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [RD_REQ_NUM-1:0] rd_vld,
    input  req_pld_t              rd_pld [RD_REQ_NUM-1:0],
    output logic [RD_REQ_NUM-1:0] rd_rdy,
    input  logic [WR_REQ_NUM-1:0] wr_vld,
    input  req_pld_t              wr_pld [WR_REQ_NUM-1:0],
    output logic [WR_REQ_NUM-1:0] wr_rdy,
    output logic                  grant_vld0,
    output req_pld_t              grant_pld0,
    output logic                  grant_vld1,
    output req_pld_t              grant_pld1,
    input  logic [1:0]            grant_rdy    // from the srams
);

    logic [RAM_NUM-1:0][RAM_TIMER_W-1:0] ram_busy;
    logic [CH_NUM-1:0][CH_TIMER_W-1:0]   ch_busy;

    logic [REQ_NUM-1:0] elig_ch0;
    logic [REQ_NUM-1:0] elig_ch1;
    logic [REQ_NUM-1:0] gnt0;
    logic [REQ_NUM-1:0] gnt1;
    logic [REQ_NUM-1:0] rdy_all;
    logic               take0;
    logic               take1;
    req_pld_t           all_pld [REQ_NUM-1:0];

    for (genvar i = 0; i < RD_REQ_NUM; i++) begin : g_rd_pld
        assign all_pld[i] = rd_pld[i];
    end
    for (genvar i = 0; i < WR_REQ_NUM; i++) begin : g_wr_pld
        assign all_pld[RD_REQ_NUM+i] = wr_pld[i];
    end

    access_hazard_check u_hazard (
        .rd_vld   (rd_vld),
        .rd_pld   (rd_pld),
        .wr_vld   (wr_vld),
        .wr_pld   (wr_pld),
        .ram_busy (ram_busy),
        .ch_busy  (ch_busy),
        .elig_ch0 (elig_ch0),
        .elig_ch1 (elig_ch1)
    );

    rr_arb u_arb0 (.clk(clk), .rst_n(rst_n), .req(elig_ch0), .take(take0), .gnt(gnt0));
    rr_arb u_arb1 (.clk(clk), .rst_n(rst_n), .req(elig_ch1), .take(take1), .gnt(gnt1));

    // one-hot grants, so a plain select is enough
    always_comb begin
        grant_pld0 = '0;
        grant_pld1 = '0;
        for (int i = 0; i < REQ_NUM; i++) begin
            if (gnt0[i]) begin
                grant_pld0 = all_pld[i];
            end
            if (gnt1[i]) begin
                grant_pld1 = all_pld[i];
            end
        end
    end

    assign grant_vld0 = |gnt0;
    assign grant_vld1 = |gnt1;
    assign take0      = grant_vld0 & grant_rdy[0];
    assign take1      = grant_vld1 & grant_rdy[1];

    assign rdy_all = (gnt0 & {REQ_NUM{grant_rdy[0]}}) | (gnt1 & {REQ_NUM{grant_rdy[1]}});
    assign rd_rdy  = rdy_all[RD_REQ_NUM-1:0];
    assign wr_rdy  = rdy_all[REQ_NUM-1:RD_REQ_NUM];

    busy_timers u_timers (
        .clk      (clk),
        .rst_n    (rst_n),
        .take0    (take0),
        .pld0     (grant_pld0),
        .take1    (take1),
        .pld1     (grant_pld1),
        .ram_busy (ram_busy),
        .ch_busy  (ch_busy)
    );

endmodule

`default_nettype wire

/* bench/tb_sram_port_arb.sv */
`default_nettype none

module tb_sram_port_arb
    import sram_arb_pkg::*;
();

    logic                  clk;
    logic                  rst_n;
    logic [RD_REQ_NUM-1:0] rd_vld;
    req_pld_t              rd_pld [RD_REQ_NUM-1:0];
    logic [RD_REQ_NUM-1:0] rd_rdy;
    logic [WR_REQ_NUM-1:0] wr_vld;
    req_pld_t              wr_pld [WR_REQ_NUM-1:0];
    logic [WR_REQ_NUM-1:0] wr_rdy;
    logic                  grant_vld0;
    req_pld_t              grant_pld0;
    logic                  grant_vld1;
    req_pld_t              grant_pld1;
    logic [1:0]            grant_rdy;

    // one entry per stimulus line, i.e. per cycle
    int                   test_q  [$];
    logic [REQ_NUM-1:0]   vld_q   [$];
    logic [3*REQ_NUM-1:0] dest_q  [$];
    logic [4*REQ_NUM-1:0] dir_q   [$];
    logic [1:0]           grdy_q  [$];
    logic                 evld0_q [$];
    logic                 evld1_q [$];
    logic [3:0]           etag0_q [$];
    logic [3:0]           etag1_q [$];
    logic [REQ_NUM-1:0]   erdy_q  [$];

    bit loaded;
    int errors;
    int test_errs;
    int checks;
    int tests_run;

    sram_port_arb dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_vld     (rd_vld),
        .rd_pld     (rd_pld),
        .rd_rdy     (rd_rdy),
        .wr_vld     (wr_vld),
        .wr_pld     (wr_pld),
        .wr_rdy     (wr_rdy),
        .grant_vld0 (grant_vld0),
        .grant_pld0 (grant_pld0),
        .grant_vld1 (grant_vld1),
        .grant_pld1 (grant_pld1),
        .grant_rdy  (grant_rdy)
    );

    always #2 clk = ~clk;

    function automatic string test_name(input int n);
        case (n)
            1:       return "steering";
            2:       return "round_robin";
            3:       return "back_pressure";
            4:       return "ram_conflict";
            5:       return "channel_conflict";
            6:       return "dual_issue";
            default: return "unnamed";
        endcase
    endfunction

    task automatic load_stimulus();
        int    fd;
        int    rc;
        int    tnum;
        string line;
        logic [REQ_NUM-1:0]   vld;
        logic [3*REQ_NUM-1:0] dest;
        logic [4*REQ_NUM-1:0] dir;
        logic [1:0]           grdy;
        logic                 ev0;
        logic                 ev1;
        logic [3:0]           et0;
        logic [3:0]           et1;
        logic [REQ_NUM-1:0]   erdy;
        fd = $fopen("bench/arb_input.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/arb_input.txt, no stimulus to run");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc   = $fgets(line, fd);
                if (line.len() > 0 && line.getc(0) != "#") begin // skip column notes
                    rc = $sscanf(line, "%d %b %o %h %b %b %b %h %h %b",
                                 tnum, vld, dest, dir, grdy, ev0, ev1, et0, et1, erdy);
                    if (rc == 10) begin
                        test_q.push_back(tnum);
                        vld_q.push_back(vld);
                        dest_q.push_back(dest);
                        dir_q.push_back(dir);
                        grdy_q.push_back(grdy);
                        evld0_q.push_back(ev0);
                        evld1_q.push_back(ev1);
                        etag0_q.push_back(et0);
                        etag1_q.push_back(et1);
                        erdy_q.push_back(erdy);
                    end else if (rc > 0) begin
                        $display("malformed stimulus line: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // tag = requester index, opcode from the requester's side
    function automatic req_pld_t req_payload(input int i, input int r);
        req_pld_t             p;
        logic [3*REQ_NUM-1:0] dests;
        logic [4*REQ_NUM-1:0] dirs;
        dests = dest_q[i];
        dirs  = dir_q[i];
        if (r < RD_REQ_NUM) begin
            p.opcode = OP_READ;
        end else if (r == RD_REQ_NUM) begin
            p.opcode = OP_LINEFILL; // write 0 is the linefill path
        end else begin
            p.opcode = OP_WRITE;
        end
        p.direction = dir_e'(dirs[4*r +: 2]);
        p.dest_ram  = dests[3*r +: 3];
        p.tag       = 4'(r);
        return p;
    endfunction

    task automatic drive_inputs(input int i);
        for (int r = 0; r < RD_REQ_NUM; r++) begin
            rd_pld[r] = req_payload(i, r);
        end
        for (int r = 0; r < WR_REQ_NUM; r++) begin
            wr_pld[r] = req_payload(i, RD_REQ_NUM + r);
        end
        rd_vld    = vld_q[i][RD_REQ_NUM-1:0];
        wr_vld    = vld_q[i][REQ_NUM-1:RD_REQ_NUM];
        grant_rdy = grdy_q[i];
    endtask

    task automatic check_outputs(input int i);
        logic [REQ_NUM-1:0] act_rdy;
        req_pld_t           exp0;
        req_pld_t           exp1;
        string              name;
        act_rdy = {wr_rdy, rd_rdy};
        exp0    = req_payload(i, int'(etag0_q[i]));
        exp1    = req_payload(i, int'(etag1_q[i]));
        name    = test_name(test_q[i]);
        checks += 3;
        if (grant_vld0 !== evld0_q[i]) begin
            $display("[FAIL] %s cycle %0d grant_vld0: expected %0b, actual %0b",
                     name, i, evld0_q[i], grant_vld0);
            test_errs++;
        end
        if (grant_vld1 !== evld1_q[i]) begin
            $display("[FAIL] %s cycle %0d grant_vld1: expected %0b, actual %0b",
                     name, i, evld1_q[i], grant_vld1);
            test_errs++;
        end
        if (evld0_q[i]) begin // payload only matters when valid
            checks++;
            if (grant_pld0 !== exp0) begin
                $display("[FAIL] %s cycle %0d grant_pld0: expected %h, actual %h",
                         name, i, exp0, grant_pld0);
                test_errs++;
            end
        end
        if (evld1_q[i]) begin
            checks++;
            if (grant_pld1 !== exp1) begin
                $display("[FAIL] %s cycle %0d grant_pld1: expected %h, actual %h",
                         name, i, exp1, grant_pld1);
                test_errs++;
            end
        end
        if (act_rdy !== erdy_q[i]) begin
            $display("[FAIL] %s cycle %0d rdy: expected %b, actual %b",
                     name, i, erdy_q[i], act_rdy);
            test_errs++;
        end
    endtask

    task automatic report_test(input int n);
        $display("test %0d %s done, %0d errors", n, test_name(n), test_errs);
        errors    += test_errs;
        test_errs  = 0;
        tests_run++;
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        rd_vld    = '0;
        wr_vld    = '0;
        grant_rdy = '0;
        for (int r = 0; r < RD_REQ_NUM; r++) begin
            rd_pld[r] = '0;
        end
        for (int r = 0; r < WR_REQ_NUM; r++) begin
            wr_pld[r] = '0;
        end
        load_stimulus();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < test_q.size(); i++) begin
            drive_inputs(i);   // 1 unit after the edge
            #2;
            check_outputs(i);  // 1 unit before the next edge
            if (i == test_q.size() - 1 || test_q[i+1] != test_q[i]) begin
                report_test(test_q[i]);
            end
            @(posedge clk);
            #1;
        end
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // bound on run time, a few cycles of slack past the last line
    initial begin
        int limit;
        wait (loaded);
        limit = test_q.size() * 4 + 200;
        #(limit);
        $display("timeout: run did not finish within %0d time units", limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/arb_input.txt */
# test valid[9:0] dest[9..0](octal) dir[9..0](hex) grant_rdy[1:0] exp_vld0 exp_vld1
# exp_tag0 exp_tag1 exp_rdy[9:0]; 0-4 read, 5 linefill, 6-9 west east south north writes
1 0000000001 0000000001 3210000000 11 0 1 0 0 0000000001
1 0000000000 0000000000 3210000000 11 0 0 0 0 0000000000
2 0000001110 0000002220 3210000000 11 1 0 1 0 0000000010
2 0000001110 0000002220 3210000000 11 1 0 2 0 0000000100
2 0000001110 0000002220 3210000000 11 1 0 3 0 0000001000
2 0000011110 0000022220 3210000000 11 1 0 4 0 0000010000
2 0000011110 0000022220 3210000000 11 1 0 1 0 0000000010
3 0000011110 0000022220 3210000000 10 1 0 2 0 0000000000
3 0000011110 0000022220 3210000000 10 1 0 2 0 0000000000
3 0000011110 0000022220 3210000000 11 1 0 2 0 0000000100
3 0000011110 0000022220 3210000000 11 1 0 3 0 0000001000
# west write at line 11, read refused at 15 (channel bit 0) and 22 (ram bit 1)
4 0001000000 0000000000 3210000000 11 1 0 6 0 0001000000
4 0000000001 0000000000 3210000000 11 1 0 0 0 0000000001
4 0000000001 0000000000 3210000000 11 1 0 0 0 0000000001
4 0000000001 0000000000 3210000000 11 1 0 0 0 0000000001
4 0000000001 0000000000 3210000000 11 0 0 0 0 0000000000
4 0000000001 0000000000 3210000000 11 1 0 0 0 0000000001
4 0000000001 0000000000 3210000000 11 1 0 0 0 0000000001
4 0000000001 0000000000 3210000000 11 1 0 0 0 0000000001
4 0000000001 0000000000 3210000000 11 1 0 0 0 0000000001
4 0000000001 0000000000 3210000000 11 1 0 0 0 0000000001
4 0000000001 0000000000 3210000000 11 1 0 0 0 0000000001
4 0000000001 0000000000 3210000000 11 0 0 0 0 0000000000
4 0000000001 0000000000 3210000000 11 1 0 0 0 0000000001
# linefill at 24, north at 25, east refused at 26, read refused at 31 and 33
5 0000100000 0000200000 3210000000 11 1 0 5 0 0000100000
5 1000000000 6000000000 3210000000 11 1 0 9 0 1000000000
5 0010000000 0040000000 3210000000 11 0 0 0 0 0000000000
5 0010000000 0040000000 3210000000 11 1 0 7 0 0010000000
5 0000000010 0000000000 3210000000 11 1 0 1 0 0000000010
5 0000000010 0000000000 3210000000 11 1 0 1 0 0000000010
5 0000000010 0000000000 3210000000 11 1 0 1 0 0000000010
5 0000000010 0000000000 3210000000 11 0 0 0 0 0000000000
5 0000000010 0000000000 3210000000 11 1 0 1 0 0000000010
5 0000000010 0000000000 3210000000 11 0 0 0 0 0000000000
6 0000001100 0000001000 3210000000 11 1 1 2 3 0000001100
6 0101000000 0304000000 3210000000 11 1 1 6 8 0101000000
6 0000000000 0000000000 3210000000 11 0 0 0 0 0000000000

/* compile.f */
rtl/sram_arb_pkg.sv
rtl/access_hazard_check.sv
rtl/busy_timers.sv
rtl/rr_arb.sv
rtl/sram_port_arb.sv
bench/tb_sram_port_arb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_sram_port_arb
RTL_TOP    := sram_port_arb
FILELIST   := compile.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
LOG        := sim.log
PASS_MSG   := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
